// File: sources.f
logic/ex_pkg.sv
logic/cla_adder.sv
logic/ex_control.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/ex_stage.sv
dv/ex_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module ex_stage_tb \
    -f sources.f \
    -o ex_stage_sim

./obj_dir/ex_stage_sim 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "sim passed" sim.log; then
    echo "Simulation ended without a pass report"
    exit 1
fi

echo "Simulation passed"

// File: dv/ex_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int          num_tests    = 3000;
    localparam int          reset_cycles = 8;
    localparam int          cycle_limit  = num_tests + reset_cycles + 20;
    localparam logic [31:0] lfsr_seed    = 32'h19647597;

    logic     clk;
    logic     reset;
    ex_req_t  req;
    ex_resp_t resp;

    logic [31:0] lfsr;
    int          cycles = 0;
    ex_resp_t    exp_q[$];

    ex_stage DUT (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .resp  (resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    function automatic logic [5:0] shift_edge(logic [1:0] sel);
        case (sel)
            2'd0:    return 6'd0;
            2'd1:    return 6'd31;
            2'd2:    return 6'd32;
            default: return 6'd63;
        endcase
    endfunction

    function automatic logic known_opcode(logic [6:0] opc);
        case (opc)
            opc_op, opc_op_32, opc_op_imm, opc_op_imm_32, opc_load, opc_store,
            opc_branch, opc_jal, opc_jalr, opc_auipc, opc_lui: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [6:0] legal_opcode(logic [3:0] idx);
        case (idx)
            4'd0:    return opc_op;
            4'd1:    return opc_op_32;
            4'd2:    return opc_op_imm;
            4'd3:    return opc_op_imm_32;
            4'd4:    return opc_load;
            4'd5:    return opc_store;
            4'd6:    return opc_branch;
            4'd7:    return opc_jal;
            4'd8:    return opc_jalr;
            4'd9:    return opc_auipc;
            default: return opc_lui;
        endcase
    endfunction

    // Sign-bit extremes and shift amounts near the limits
    task automatic pick_data(output logic [63:0] v);
        logic [63:0] sel;
        logic [63:0] r;
        take_bits(3, sel);
        take_bits(64, r);
        case (sel[2:0])
            3'd0:    v = 64'h8000_0000_0000_0000;
            3'd1:    v = 64'h7fff_ffff_ffff_ffff;
            3'd2:    v = '1;
            3'd3:    v = {r[63:6], shift_edge(r[1:0])};
            3'd4:    v = '0;
            default: v = r;
        endcase
    endtask

    task automatic pick_imm(output logic [63:0] v);
        logic [63:0] sel;
        logic [63:0] r;
        take_bits(2, sel);
        take_bits(20, r);
        case (sel[1:0])
            2'd0:    v = {58'b0, shift_edge(r[1:0])};
            2'd1:    v = {{52{r[11]}}, r[11:0]};
            2'd2:    v = {{44{r[19]}}, r[19:0]};
            default: v = {{51{r[12]}}, r[12:1], 1'b0};
        endcase
    endtask

    task automatic pick_request(output ex_req_t r);
        logic [63:0] bits;
        logic [3:0]  idx;
        logic [6:0]  opc;
        take_bits(4, bits);
        if (bits[3:0] == 4'd0) begin
            take_bits(7, bits);
            while (known_opcode(bits[6:0])) begin
                take_bits(7, bits);
            end
            opc = bits[6:0];
        end else begin
            idx = (bits[3:0] - 4'd1) % 4'd11;
            opc = legal_opcode(idx);
        end
        r.opcode = opcode_e'(opc);
        take_bits(3, bits);
        r.func3 = bits[2:0];
        take_bits(2, bits);
        case (bits[1:0])
            2'd2:    r.func7 = func7_alt;
            2'd3:    begin
                take_bits(7, bits);
                r.func7 = bits[6:0];
            end
            default: r.func7 = func7_base;
        endcase
        pick_imm(r.imm);
        pick_data(r.data1);
        pick_data(r.data2);
        // Equal operands for the compares
        take_bits(2, bits);
        if (bits[1:0] == 2'd0) begin
            r.data2 = r.data1;
        end
        take_bits(32, bits);
        r.pc = bits[31:0];
    endtask

    function automatic logic [63:0] full_op(logic [2:0] f3, logic alt, logic [63:0] a,
                                            logic [63:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'b0, $signed(a) < $signed(b)};
            3'd3:    return {63'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [63:0] word_op(logic [2:0] f3, logic alt, logic [63:0] a,
                                            logic [63:0] b);
        logic [31:0] w;
        case (f3)
            3'd0:    w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'd1:    w = a[31:0] << b[4:0];
            3'd5:    w = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
            default: w = '0;
        endcase
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [63:0] a, logic [63:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Expected response by RV64I rules
    function automatic ex_resp_t model_resp(ex_req_t r);
        ex_resp_t    e;
        logic [63:0] upper;
        logic [63:0] link;
        logic [2:0]  f3;
        logic [5:0]  func6;
        logic        base;
        logic        alt;
        logic        taken;
        e     = '0;
        f3    = r.func3;
        func6 = r.func7[6:1];
        base  = (r.func7 == 7'h00);
        alt   = (r.func7 == 7'h20);
        upper = {{32{r.imm[19]}}, r.imm[19:0], 12'b0};
        link  = {32'b0, r.pc} + 64'd4;
        case (r.opcode)
            opc_op: begin
                if (base || (alt && (f3 == 3'd0 || f3 == 3'd5))) begin
                    e.result = full_op(f3, alt, r.data1, r.data2);
                end
            end
            opc_op_32: begin
                if (((f3 == 3'd0 || f3 == 3'd5) && (base || alt)) || (f3 == 3'd1 && base)) begin
                    e.result = word_op(f3, alt, r.data1, r.data2);
                end
            end
            opc_op_imm: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    if (func6 == 6'h00) begin
                        e.result = full_op(f3, 1'b0, r.data1, r.imm);
                    end else if (func6 == 6'h10 && f3 == 3'd5) begin
                        e.result = full_op(f3, 1'b1, r.data1, r.imm);
                    end
                end else begin
                    e.result = full_op(f3, 1'b0, r.data1, r.imm);
                end
            end
            opc_op_imm_32: begin
                if (f3 == 3'd0 || (f3 == 3'd1 && base) || (f3 == 3'd5 && (base || alt))) begin
                    e.result = word_op(f3, alt && f3 == 3'd5, r.data1, r.imm);
                end
            end
            opc_load: begin
                if (f3 != 3'd7) begin
                    e.result  = r.data1 + r.imm;
                    e.is_load = 1'b1;
                end
            end
            opc_store: begin
                if (f3 < 3'd4) begin
                    e.result = r.data1 + r.imm;
                    e.mem_rw = 1'b1;
                end
            end
            opc_branch: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    taken       = branch_taken(f3, r.data1, r.data2);
                    e.is_branch = taken;
                    e.pc_branch = taken ? r.pc + r.imm[31:0] : r.pc + 32'd4;
                end
            end
            opc_jal: begin
                e.result    = link;
                e.is_branch = 1'b1;
                e.pc_branch = r.pc + r.imm[31:0];
            end
            opc_jalr: begin
                if (f3 == 3'd0) begin
                    e.result    = link;
                    e.is_branch = 1'b1;
                    e.pc_branch = (r.data1[31:0] + r.imm[31:0]) & ~32'h1;
                end
            end
            opc_auipc: e.result = {32'b0, r.pc} + upper;
            opc_lui:   e.result = upper;
            default: ;
        endcase
        return e;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
            $display("sim failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic compare_resp(input ex_resp_t e);
        check_field("resp.result", e.result, resp.result);
        check_field("resp.pc_branch", 64'(e.pc_branch), 64'(resp.pc_branch));
        check_field("resp.is_branch", 64'(e.is_branch), 64'(resp.is_branch));
        check_field("resp.mem_rw", 64'(e.mem_rw), 64'(resp.mem_rw));
        check_field("resp.is_load", 64'(e.is_load), 64'(resp.is_load));
    endtask

    initial begin
        ex_req_t  r;
        ex_resp_t e;
        lfsr  = lfsr_seed;
        reset = 1'b1;
        pick_request(r);
        req = r;
        // Live requests during reset must not reach resp
        repeat (reset_cycles - 1) begin
            @(posedge clk);
            #1;
            pick_request(r);
            req = r;
            @(negedge clk);
            compare_resp('0);
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            pick_request(r);
            req = r;
            exp_q.push_back(model_resp(r));
            @(negedge clk);
            if (i == 0) begin
                // Nothing captured yet, register still clear
                compare_resp('0);
            end else begin
                e = exp_q.pop_front();
                compare_resp(e);
            end
            @(posedge clk);
            #1;
        end
        // Newer input on req while the last response is checked
        pick_request(r);
        req = r;
        @(negedge clk);
        e = exp_q.pop_front();
        compare_resp(e);
        $display("sim passed");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $fatal(1, "Timeout");
        end
    end

endmodule

`default_nettype wire

// File: logic/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  ex_req_t  req,
    output ex_resp_t resp
);

    alu_ctrl_t           alu_ctrl;
    branch_kind_e        branch_kind;
    branch_func_e        branch_func;
    logic                mem_rw;
    logic                is_load;
    logic [xlen-1:0]     result;
    logic [pc_width-1:0] pc_branch;
    logic                is_branch;
    ex_resp_t            resp_next;

    ex_control u_control (
        .opcode      (req.opcode),
        .func3       (req.func3),
        .func7       (req.func7),
        .alu_ctrl    (alu_ctrl),
        .branch_kind (branch_kind),
        .branch_func (branch_func),
        .mem_rw      (mem_rw),
        .is_load     (is_load)
    );

    int_alu u_alu (
        .ctrl   (alu_ctrl),
        .data1  (req.data1),
        .data2  (req.data2),
        .imm    (req.imm),
        .pc     (req.pc),
        .result (result)
    );

    branch_unit u_branch (
        .kind      (branch_kind),
        .cond      (branch_func),
        .data1     (req.data1),
        .data2     (req.data2),
        .imm       (req.imm),
        .pc        (req.pc),
        .pc_branch (pc_branch),
        .is_branch (is_branch)
    );

    assign resp_next = '{result, pc_branch, is_branch, mem_rw, is_load};

    // EX/MEM pipeline register
    always_ff @(posedge clk) begin
        if (reset) begin
            resp <= '0;
        end else begin
            resp <= resp_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit
    import ex_pkg::*;
(
    input  branch_kind_e        kind,
    input  branch_func_e        cond,
    input  logic [xlen-1:0]     data1,
    input  logic [xlen-1:0]     data2,
    input  logic [xlen-1:0]     imm,
    input  logic [pc_width-1:0] pc,
    output logic [pc_width-1:0] pc_branch,
    output logic                is_branch
);

    logic [xlen-1:0] pc_ext;
    logic [xlen-1:0] target_sum;
    logic [xlen-1:0] fall_sum;
    logic [xlen-1:0] jalr_sum;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            taken;

    assign pc_ext = {{(xlen-pc_width){1'b0}}, pc};

    cla_adder u_target (
        .a        (pc_ext),
        .b        (imm),
        .carry_in (1'b0),
        .sum      (target_sum)
    );

    cla_adder u_fall (
        .a        (pc_ext),
        .b        (xlen'(4)),
        .carry_in (1'b0),
        .sum      (fall_sum)
    );

    cla_adder u_jalr (
        .a        (data1),
        .b        (imm),
        .carry_in (1'b0),
        .sum      (jalr_sum)
    );

    assign eq   = (data1 == data2);
    assign lt_s = ($signed(data1) < $signed(data2));
    assign lt_u = (data1 < data2);

    always_comb begin
        case (cond)
            br_beq:  taken = eq;
            br_bne:  taken = !eq;
            br_blt:  taken = lt_s;
            br_bge:  taken = !lt_s;
            br_bltu: taken = lt_u;
            br_bgeu: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        is_branch = 1'b0;
        pc_branch = '0;
        case (kind)
            bk_cond: begin
                is_branch = taken;
                pc_branch = taken ? target_sum[pc_width-1:0] : fall_sum[pc_width-1:0];
            end
            bk_jal: begin
                is_branch = 1'b1;
                pc_branch = target_sum[pc_width-1:0];
            end
            bk_jalr: begin
                // Target LSB always cleared
                is_branch = 1'b1;
                pc_branch = {jalr_sum[pc_width-1:1], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/int_alu.sv
`timescale 1ns/100ps
`default_nettype none

module int_alu
    import ex_pkg::*;
(
    input  alu_ctrl_t           ctrl,
    input  logic [xlen-1:0]     data1,
    input  logic [xlen-1:0]     data2,
    input  logic [xlen-1:0]     imm,
    input  logic [pc_width-1:0] pc,
    output logic [xlen-1:0]     result
);

    logic [xlen-1:0]        op_a;
    logic [xlen-1:0]        op_b;
    logic [xlen-1:0]        upper_imm;
    logic [xlen-1:0]        add_b;
    logic [xlen-1:0]        sum;
    logic                   is_sub;
    logic [shamt_width-1:0] shamt;
    logic [xlen-1:0]        srl_src;
    logic [xlen-1:0]        sra_src;
    logic [xlen-1:0]        raw;

    // U-type immediate sits in imm[19:0]
    assign upper_imm = {{(xlen-32){imm[19]}}, imm[19:0], 12'b0};

    always_comb begin
        case (ctrl.src_a)
            src_a_reg: op_a = data1;
            src_a_pc:  op_a = {{(xlen-pc_width){1'b0}}, pc};
            default:   op_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.src_b)
            src_b_reg:       op_b = data2;
            src_b_imm:       op_b = imm;
            src_b_upper_imm: op_b = upper_imm;
            src_b_four:      op_b = xlen'(4);
            default:         op_b = '0;
        endcase
    end

    // Subtract as a + ~b + 1
    assign is_sub = (ctrl.op == alu_sub);
    assign add_b  = op_b ^ {xlen{is_sub}};

    cla_adder u_add (
        .a        (op_a),
        .b        (add_b),
        .carry_in (is_sub),
        .sum      (sum)
    );

    assign shamt = ctrl.word ? {1'b0, op_b[word_shamt_width-1:0]} : op_b[shamt_width-1:0];

    // Word shifts right start from the low word, zero or sign filled
    assign srl_src = ctrl.word ? {{(xlen-word_width){1'b0}}, op_a[word_width-1:0]} : op_a;
    assign sra_src = ctrl.word ? {{(xlen-word_width){op_a[word_width-1]}},
                                  op_a[word_width-1:0]} : op_a;

    always_comb begin
        case (ctrl.op)
            alu_add,
            alu_sub:    raw = sum;
            alu_sll:    raw = op_a << shamt;
            alu_slt:    raw = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu:   raw = xlen'(op_a < op_b);
            alu_xor:    raw = op_a ^ op_b;
            alu_srl:    raw = srl_src >> shamt;
            alu_sra:    raw = $signed(sra_src) >>> shamt;
            alu_or:     raw = op_a | op_b;
            alu_and:    raw = op_a & op_b;
            alu_pass_b: raw = op_b;
            default:    raw = '0;
        endcase
    end

    assign result = ctrl.word ? {{(xlen-word_width){raw[word_width-1]}}, raw[word_width-1:0]}
                              : raw;

endmodule

`default_nettype wire

// File: logic/ex_control.sv
`timescale 1ns/100ps
`default_nettype none

module ex_control
    import ex_pkg::*;
(
    input  opcode_e      opcode,
    input  logic [2:0]   func3,
    input  logic [6:0]   func7,
    output alu_ctrl_t    alu_ctrl,
    output branch_kind_e branch_kind,
    output branch_func_e branch_func,
    output logic         mem_rw,
    output logic         is_load
);

    alu_op_e base_op;
    alu_op_e alt_op;
    logic    f3_has_alt;
    logic    word_f3_ok;

    always_comb begin
        case (func3_e'(func3))
            f3_add_sub: base_op = alu_add;
            f3_sll:     base_op = alu_sll;
            f3_slt:     base_op = alu_slt;
            f3_sltu:    base_op = alu_sltu;
            f3_xor:     base_op = alu_xor;
            f3_srl_sra: base_op = alu_srl;
            f3_or:      base_op = alu_or;
            f3_and:     base_op = alu_and;
            default:    base_op = alu_pass_b;
        endcase
    end

    // func7 bit 5 turns add into sub and srl into sra
    assign alt_op     = (func3_e'(func3) == f3_srl_sra) ? alu_sra : alu_sub;
    assign f3_has_alt = (func3_e'(func3) == f3_add_sub) || (func3_e'(func3) == f3_srl_sra);
    assign word_f3_ok = f3_has_alt || (func3_e'(func3) == f3_sll);

    assign branch_func = branch_func_e'(func3);

    always_comb begin
        alu_ctrl    = '{alu_pass_b, src_a_zero, src_b_zero, 1'b0};
        branch_kind = bk_none;
        mem_rw      = 1'b0;
        is_load     = 1'b0;
        case (opcode)
            opc_op, opc_op_32: begin
                if (opcode == opc_op || word_f3_ok) begin
                    if (func7 == func7_base) begin
                        alu_ctrl = '{base_op, src_a_reg, src_b_reg, opcode == opc_op_32};
                    end else if (func7 == func7_alt && f3_has_alt) begin
                        alu_ctrl = '{alt_op, src_a_reg, src_b_reg, opcode == opc_op_32};
                    end
                end
            end
            opc_op_imm: begin
                // Upper func7 bits only; bit 0 is shamt[5]
                case (func3_e'(func3))
                    f3_sll: begin
                        if (func7[6:1] == func7_base[6:1]) begin
                            alu_ctrl = '{alu_sll, src_a_reg, src_b_imm, 1'b0};
                        end
                    end
                    f3_srl_sra: begin
                        if (func7[6:1] == func7_base[6:1]) begin
                            alu_ctrl = '{alu_srl, src_a_reg, src_b_imm, 1'b0};
                        end else if (func7[6:1] == func7_alt[6:1]) begin
                            alu_ctrl = '{alu_sra, src_a_reg, src_b_imm, 1'b0};
                        end
                    end
                    default: alu_ctrl = '{base_op, src_a_reg, src_b_imm, 1'b0};
                endcase
            end
            opc_op_imm_32: begin
                case (func3_e'(func3))
                    f3_add_sub: alu_ctrl = '{alu_add, src_a_reg, src_b_imm, 1'b1};
                    f3_sll: begin
                        if (func7 == func7_base) begin
                            alu_ctrl = '{alu_sll, src_a_reg, src_b_imm, 1'b1};
                        end
                    end
                    f3_srl_sra: begin
                        if (func7 == func7_base) begin
                            alu_ctrl = '{alu_srl, src_a_reg, src_b_imm, 1'b1};
                        end else if (func7 == func7_alt) begin
                            alu_ctrl = '{alu_sra, src_a_reg, src_b_imm, 1'b1};
                        end
                    end
                    default: ;
                endcase
            end
            opc_load: begin
                if (func3 != 3'b111) begin
                    alu_ctrl = '{alu_add, src_a_reg, src_b_imm, 1'b0};
                    is_load  = 1'b1;
                end
            end
            opc_store: begin
                if (!func3[2]) begin
                    alu_ctrl = '{alu_add, src_a_reg, src_b_imm, 1'b0};
                    mem_rw   = 1'b1;
                end
            end
            opc_branch: begin
                if (func3[2:1] != 2'b01) begin
                    branch_kind = bk_cond;
                end
            end
            opc_jal: begin
                alu_ctrl    = '{alu_add, src_a_pc, src_b_four, 1'b0};
                branch_kind = bk_jal;
            end
            opc_jalr: begin
                if (func3 == 3'b000) begin
                    alu_ctrl    = '{alu_add, src_a_pc, src_b_four, 1'b0};
                    branch_kind = bk_jalr;
                end
            end
            opc_auipc: alu_ctrl = '{alu_add, src_a_pc, src_b_upper_imm, 1'b0};
            opc_lui:   alu_ctrl = '{alu_pass_b, src_a_zero, src_b_upper_imm, 1'b0};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cla_adder.sv
`timescale 1ns/100ps
`default_nettype none

module cla_adder
    import ex_pkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic            carry_in,
    output logic [xlen-1:0] sum
);

    // Carry into each 8-bit group
    logic [cla_groups:0]   grp_carry;
    logic [cla_groups-1:0] group_p;
    logic [cla_groups-1:0] group_g;

    for (genvar k = 0; k < cla_groups; k++) begin : g_group
        logic [cla_group-1:0] p;
        logic [cla_group-1:0] g;
        logic [cla_group-1:0] c;
        logic                 grp_p;
        logic                 grp_g;

        assign p = a[k*cla_group +: cla_group] ^ b[k*cla_group +: cla_group];
        assign g = a[k*cla_group +: cla_group] & b[k*cla_group +: cla_group];

        always_comb begin
            c[0] = grp_carry[k];
            for (int i = 1; i < cla_group; i++) begin
                c[i] = g[i-1] | (p[i-1] & c[i-1]);
            end
        end

        // Group propagate and generate feed the next group directly
        always_comb begin
            grp_p = 1'b1;
            grp_g = 1'b0;
            for (int i = 0; i < cla_group; i++) begin
                grp_g = g[i] | (p[i] & grp_g);
                grp_p = grp_p & p[i];
            end
        end

        assign group_p[k] = grp_p;
        assign group_g[k] = grp_g;
        assign sum[k*cla_group +: cla_group] = p ^ c;
    end

    // Carries ripple from group to group
    always_comb begin
        grp_carry[0] = carry_in;
        for (int k = 0; k < cla_groups; k++) begin
            grp_carry[k+1] = group_g[k] | (group_p[k] & grp_carry[k]);
        end
    end

endmodule

`default_nettype wire

// File: logic/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int xlen             = 64;
    localparam int pc_width         = 32;
    localparam int word_width       = 32;
    localparam int shamt_width      = $clog2(xlen);
    localparam int word_shamt_width = $clog2(word_width);

    // Adder is split into lookahead groups of this width
    localparam int cla_group  = 8;
    localparam int cla_groups = xlen / cla_group;

    localparam logic [6:0] func7_base = 7'b0000000;
    localparam logic [6:0] func7_alt  = 7'b0100000;

    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_32     = 7'b0111011,
        opc_op_imm    = 7'b0010011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_branch    = 7'b1100011,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_auipc     = 7'b0010111,
        opc_lui       = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } func3_e;

    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_func_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        src_a_reg,
        src_a_pc,
        src_a_zero
    } src_a_e;

    // Zero source is what illegal encodings select
    typedef enum logic [2:0] {
        src_b_reg,
        src_b_imm,
        src_b_upper_imm,
        src_b_four,
        src_b_zero
    } src_b_e;

    typedef enum logic [1:0] {
        bk_none,
        bk_cond,
        bk_jal,
        bk_jalr
    } branch_kind_e;

    typedef struct packed {
        alu_op_e op;
        src_a_e  src_a;
        src_b_e  src_b;
        logic    word;
    } alu_ctrl_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [2:0]            func3;
        logic [6:0]            func7;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       data1;
        logic [xlen-1:0]       data2;
        logic [pc_width-1:0]   pc;
    } ex_req_t;

    typedef struct packed {
        logic [xlen-1:0]       result;
        logic [pc_width-1:0]   pc_branch;
        logic                  is_branch;
        logic                  mem_rw;
        logic                  is_load;
    } ex_resp_t;

endpackage

`default_nettype wire
